/* encoder_pkg.sv */
// Sizes and the register map assume exactly two channels with a 16 bit count that is also the bus width
`default_nettype none

package encoder_pkg;

    // ##################################################
    // Sizes
    // ##################################################

    // Number of encoder channels served by the peripheral
    localparam int num_channels = 2;

    // Tick count width, also the host data width
    localparam int count_width = 16;

    // Register address width
    localparam int addr_width = 2;

    // Equal synchronized samples needed before a filtered line flips
    localparam int filter_len = 3;

    // Direction level that counts up
    localparam logic dir_fwd = 1'b0;

    // ##################################################
    // Register map and bus types
    // ##################################################

    // Host register addresses
    typedef enum logic [addr_width-1:0] {
        addr_ctrl   = 2'd0,
        addr_count0 = 2'd1,
        addr_count1 = 2'd2,
        addr_status = 2'd3
    } reg_addr_t;

    // Host request, wr and rd are single cycle strobes
    typedef struct packed {
        logic                   wr;
        logic                   rd;
        reg_addr_t              addr;
        logic [count_width-1:0] wdata;
    } reg_req_t;

    // One counter output, valid strobes with each enabled tick
    typedef struct packed {
        logic                   valid;
        logic [count_width-1:0] count;
    } count_sample_t;

endpackage

`default_nettype wire

/* input_sync.sv */
// Asynchronous inputs reach the outputs 5 cycles after a stable change and pulses under 3 cycles are dropped
`timescale 1ns/10ps
`default_nettype none

module input_sync (
    input  logic clk,
    input  logic reset,
    input  logic pulse_raw,
    input  logic dir_raw,
    output logic pulse_filt,
    output logic dir_filt
);
    import encoder_pkg::*;

    // Run counter wide enough to reach filter_len - 1
    typedef logic [$clog2(filter_len)-1:0] run_t;

    // Bit 0 carries the pulse line and bit 1 the direction line
    logic [1:0] raw;
    logic [1:0] sync_meta;
    logic [1:0] sync_q;
    logic [1:0] filt_q;
    run_t       run_cnt [2];

    assign raw = {dir_raw, pulse_raw};

    // ##################################################
    // Two flop synchronizer
    // ##################################################

    // First stage may go metastable, second stage is the usable copy
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= raw;
            sync_q    <= sync_meta;
        end
    end

    // ##################################################
    // Glitch filter
    // ##################################################

    // Count consecutive samples that disagree with the filtered level
    // Any agreeing sample restarts the run
    always_ff @(posedge clk) begin
        if (reset) begin
            filt_q <= '0;
            for (int i = 0; i < 2; i++) begin
                run_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (sync_q[i] != filt_q[i]) begin
                    // Third disagreeing sample in a row flips the output
                    if (run_cnt[i] == run_t'(filter_len - 1)) begin
                        filt_q[i]  <= sync_q[i];
                        run_cnt[i] <= '0;
                    end else begin
                        run_cnt[i] <= run_cnt[i] + 1'b1;
                    end
                end else begin
                    run_cnt[i] <= '0;
                end
            end
        end
    end

    // Filtered levels go straight to the counter
    assign pulse_filt = filt_q[0];
    assign dir_filt   = filt_q[1];

endmodule

`default_nettype wire

/* pulse_counter.sv */
// Inputs must already be synchronous and filtered and the count wraps modulo 2^16 in both directions
`timescale 1ns/10ps
`default_nettype none

module pulse_counter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        en,
    input  logic                        pulse_in,
    input  logic                        dir_in,
    output encoder_pkg::count_sample_t  sample
);
    import encoder_pkg::*;

    // Previous pulse level for edge detection
    logic pulse_d;
    logic pulse_rise;

    // Running tick count and its update strobe
    logic [count_width-1:0] count_q;
    logic                   valid_q;

    // ##################################################
    // Edge detect
    // ##################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            pulse_d <= 1'b0;
        end else begin
            pulse_d <= pulse_in;
        end
    end

    assign pulse_rise = pulse_in & ~pulse_d;

    // ##################################################
    // Up/down count
    // ##################################################

    // The count runs even while disabled
    // valid only fires when enabled so the register block keeps its shadow frozen
    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (pulse_rise) begin
                if (dir_in == dir_fwd) begin
                    count_q <= count_q + 1'b1;
                end else begin
                    count_q <= count_q - 1'b1;
                end
                valid_q <= en;
            end
        end
    end

    assign sample.valid = valid_q;
    assign sample.count = count_q;

endmodule

`default_nettype wire

/* encoder_regs.sv */
// Register map assumes two channels and reads return one cycle after rd with status cleared on read
`timescale 1ns/10ps
`default_nettype none

module encoder_regs (
    input  logic                                     clk,
    input  logic                                     reset,
    input  encoder_pkg::reg_req_t                    req,
    input  encoder_pkg::count_sample_t               samples [encoder_pkg::num_channels],
    output logic [encoder_pkg::num_channels-1:0]     en,
    output logic [encoder_pkg::count_width-1:0]      rdata,
    output logic                                     rvalid
);
    import encoder_pkg::*;

    // Per channel enable bits
    logic [num_channels-1:0] ctrl_q;

    // Last captured count per channel
    logic [count_width-1:0]  shadow_q [num_channels];

    // Sticky update flags
    logic [num_channels-1:0] status_q;
    logic [num_channels-1:0] status_set;

    // Decoded host strobes
    logic ctrl_wr;
    logic status_rd;

    // Registered read path
    logic [count_width-1:0]  rdata_q;
    logic [count_width-1:0]  rdata_mux;
    logic                    rvalid_q;

    // ##################################################
    // Host decode
    // ##################################################

    assign ctrl_wr   = req.wr && (req.addr == addr_ctrl);
    assign status_rd = req.rd && (req.addr == addr_status);

    // Writes to other addresses are read-only and fall through
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q <= '0;
        end else if (ctrl_wr) begin
            ctrl_q <= req.wdata[num_channels-1:0];
        end
    end

    // Each counter is gated by its ctrl bit
    assign en = ctrl_q;

    // ##################################################
    // Shadow counts and status
    // ##################################################

    // Collect this cycle's valid strobes
    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            status_set[i] = samples[i].valid;
        end
    end

    // Shadow loads only on valid, so a disabled channel holds its value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_channels; i++) begin
                shadow_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_channels; i++) begin
                if (samples[i].valid) begin
                    shadow_q[i] <= samples[i].count;
                end
            end
        end
    end

    // A status read clears old flags but keeps any set in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            status_q <= '0;
        end else if (status_rd) begin
            status_q <= status_set;
        end else begin
            status_q <= status_q | status_set;
        end
    end

    // ##################################################
    // Read path
    // ##################################################

    // Narrow registers are zero extended to the bus width
    always_comb begin
        case (req.addr)
            addr_ctrl:   rdata_mux = {{(count_width - num_channels){1'b0}}, ctrl_q};
            addr_count0: rdata_mux = shadow_q[0];
            addr_count1: rdata_mux = shadow_q[1];
            addr_status: rdata_mux = {{(count_width - num_channels){1'b0}}, status_q};
            default:     rdata_mux = '0;
        endcase
    end

    // Data is captured only on rd and then held
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_q  <= '0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req.rd;
            if (req.rd) begin
                rdata_q <= rdata_mux;
            end
        end
    end

    assign rdata  = rdata_q;
    assign rvalid = rvalid_q;

endmodule

`default_nettype wire

/* encoder_if_top.sv */
// Encoder pins are asynchronous and the host bus must share clk with at most one strobe per cycle
`timescale 1ns/10ps
`default_nettype none

module encoder_if_top (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [encoder_pkg::num_channels-1:0]  pulse_in,
    input  logic [encoder_pkg::num_channels-1:0]  dir_in,
    input  encoder_pkg::reg_req_t                 req,
    output logic [encoder_pkg::count_width-1:0]   rdata,
    output logic                                  rvalid
);
    import encoder_pkg::*;

    // Filtered levels per channel
    logic [num_channels-1:0] pulse_filt;
    logic [num_channels-1:0] dir_filt;

    // Counter enables from the ctrl register
    logic [num_channels-1:0] en;

    // Counter outputs into the register block
    count_sample_t           samples [num_channels];

    // ##################################################
    // Per channel datapath
    // ##################################################

    // Synchronizer and filter feed one tick counter per channel
    for (genvar i = 0; i < num_channels; i++) begin : g_channel

        input_sync u_input_sync (
            .clk        (clk),
            .reset      (reset),
            .pulse_raw  (pulse_in[i]),
            .dir_raw    (dir_in[i]),
            .pulse_filt (pulse_filt[i]),
            .dir_filt   (dir_filt[i])
        );

        pulse_counter u_pulse_counter (
            .clk      (clk),
            .reset    (reset),
            .en       (en[i]),
            .pulse_in (pulse_filt[i]),
            .dir_in   (dir_filt[i]),
            .sample   (samples[i])
        );

    end

    // ##################################################
    // Host registers
    // ##################################################

    encoder_regs u_encoder_regs (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .samples (samples),
        .en      (en),
        .rdata   (rdata),
        .rvalid  (rvalid)
    );

endmodule

`default_nettype wire

/* tb_encoder_if.sv */
// Encoder pulses are held well above the filter length and the run stops at the first mismatch
`timescale 1ns/10ps
`default_nettype none

module tb_encoder_if;
    import encoder_pkg::*;

    // ##################################################
    // Timing and step table types
    // ##################################################

    localparam int clk_period   = 10;
    localparam int reset_cycles = 8;
    localparam int drive_delay  = 1;
    localparam int dir_settle   = 8;
    localparam int pulse_high   = 8;
    localparam int pulse_margin = 16;
    localparam int read_timeout = 20;

    typedef logic [$clog2(num_channels)-1:0] chan_t;

    // Kinds of table rows
    typedef enum logic [2:0] {
        step_write,
        step_pulses,
        step_rand_pulses,
        step_read,
        step_read_model,
        step_glitch
    } step_kind_t;

    // One table row, value is write data or the literal read expectation
    typedef struct packed {
        step_kind_t             kind;
        chan_t                  chan;
        logic                   dir;
        logic [7:0]             n;
        reg_addr_t              addr;
        logic [count_width-1:0] value;
    } step_t;

    // DUT signals
    logic                    clk;
    logic                    reset;
    logic [num_channels-1:0] pulse_in;
    logic [num_channels-1:0] dir_in;
    reg_req_t                req;
    logic [count_width-1:0]  rdata;
    logic                    rvalid;

    step_t steps [$];

    // Reference model state
    logic [count_width-1:0]  run_count [num_channels];
    logic [count_width-1:0]  shadow [num_channels];
    logic [num_channels-1:0] exp_ctrl;
    logic [num_channels-1:0] exp_status;

    encoder_if_top u_encoder_if_top (
        .clk      (clk),
        .reset    (reset),
        .pulse_in (pulse_in),
        .dir_in   (dir_in),
        .req      (req),
        .rdata    (rdata),
        .rvalid   (rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ##################################################
    // Helpers
    // ##################################################

    // Always returns just after a rising edge, where inputs get driven
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #drive_delay;
    endtask

    task automatic check_value(input string name, input logic [count_width-1:0] expected,
                               input logic [count_width-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR: time %0t signal %s expected %0d actual %0d",
                     $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic add_step(input step_kind_t kind, input int chan, input logic dir,
                            input int n, input reg_addr_t addr,
                            input logic [count_width-1:0] value);
        step_t s;
        s.kind  = kind;
        s.chan  = chan_t'(chan);
        s.dir   = dir;
        s.n     = 8'(n);
        s.addr  = addr;
        s.value = value;
        steps.push_back(s);
    endtask

    // Model of one filtered tick on channel c
    task automatic model_pulse(input int c, input logic d);
        if (d == dir_fwd) begin
            run_count[c] = run_count[c] + 1'b1;
        end else begin
            run_count[c] = run_count[c] - 1'b1;
        end
        if (exp_ctrl[c]) begin
            shadow[c]     = run_count[c];
            exp_status[c] = 1'b1;
        end
    endtask

    function automatic logic [count_width-1:0] model_value(input reg_addr_t addr);
        case (addr)
            addr_ctrl:   model_value = count_width'(exp_ctrl);
            addr_count0: model_value = shadow[0];
            addr_count1: model_value = shadow[1];
            default:     model_value = count_width'(exp_status);
        endcase
    endfunction

    // ##################################################
    // Pin and bus drivers
    // ##################################################

    // Direction settles first so it is stable around each rising edge
    task automatic send_pulses(input int c, input logic d, input int n);
        dir_in[c] = d;
        wait_cycles(dir_settle);
        for (int k = 0; k < n; k++) begin
            pulse_in[c] = 1'b1;
            wait_cycles(pulse_high);
            pulse_in[c] = 1'b0;
            // Low time doubles as the margin to the readable shadow
            wait_cycles(pulse_margin);
            model_pulse(c, d);
        end
    endtask

    // Longest high time that the filter must still drop
    task automatic send_glitch(input int c);
        pulse_in[c] = 1'b1;
        wait_cycles(filter_len - 1);
        pulse_in[c] = 1'b0;
        wait_cycles(pulse_margin);
    endtask

    task automatic write_reg(input reg_addr_t addr, input logic [count_width-1:0] data);
        req.wr    = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        wait_cycles(1);
        req.wr    = 1'b0;
    endtask

    // One cycle rd strobe, then poll rvalid with a bound
    task automatic read_reg(input reg_addr_t addr, output logic [count_width-1:0] data);
        int waited;
        req.rd   = 1'b1;
        req.addr = addr;
        wait_cycles(1);
        req.rd   = 1'b0;
        waited   = 0;
        while (!rvalid && waited < read_timeout) begin
            wait_cycles(1);
            waited++;
        end
        if (!rvalid) begin
            $display("Timeout: rvalid did not rise within %0d cycles of a read", read_timeout);
            $display("** FAIL **");
            $fatal(1, "Read timeout");
        end
        data = rdata;
        wait_cycles(1);
        // rvalid is a single cycle pulse
        check_value("rvalid", '0, count_width'(rvalid));
    endtask

    // ##################################################
    // Step table
    // ##################################################

    task automatic build_table();
        // Reset values and pulses while every channel is disabled
        add_step(step_read,       0, 1'b0, 0, addr_ctrl,   16'd0);
        add_step(step_read,       0, 1'b0, 0, addr_count0, 16'd0);
        add_step(step_read,       0, 1'b0, 0, addr_count1, 16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_status, 16'd0);
        add_step(step_pulses,     0, 1'b0, 3, addr_ctrl,   16'd0);
        add_step(step_pulses,     0, 1'b1, 3, addr_ctrl,   16'd0);
        add_step(step_pulses,     1, 1'b1, 2, addr_ctrl,   16'd0);
        add_step(step_read,       0, 1'b0, 0, addr_count0, 16'd0);
        add_step(step_read,       0, 1'b0, 0, addr_count1, 16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_status, 16'd0);
        // Channel 0 up, then down through zero
        add_step(step_write,  0, 1'b0, 0, addr_ctrl,   16'd1);
        add_step(step_read,   0, 1'b0, 0, addr_ctrl,   16'd1);
        add_step(step_pulses, 0, 1'b0, 5, addr_ctrl,   16'd0);
        add_step(step_read,   0, 1'b0, 0, addr_count0, 16'd5);
        add_step(step_pulses, 0, 1'b1, 8, addr_ctrl,   16'd0);
        add_step(step_read,   0, 1'b0, 0, addr_count0, 16'd65533);
        add_step(step_read,   0, 1'b0, 0, addr_count1, 16'd0);
        // A write to a read-only register changes nothing
        add_step(step_write,      0, 1'b0, 0, addr_count0, 16'hbeef);
        add_step(step_read,       0, 1'b0, 0, addr_count0, 16'd65533);
        add_step(step_read_model, 0, 1'b0, 0, addr_status, 16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_status, 16'd0);
        // Interleaved random bursts on both channels
        add_step(step_write,       0, 1'b0, 0, addr_ctrl,   16'd3);
        add_step(step_rand_pulses, 0, 1'b0, 0, addr_ctrl,   16'd0);
        add_step(step_rand_pulses, 1, 1'b0, 0, addr_ctrl,   16'd0);
        add_step(step_rand_pulses, 1, 1'b0, 0, addr_ctrl,   16'd0);
        add_step(step_rand_pulses, 0, 1'b0, 0, addr_ctrl,   16'd0);
        add_step(step_read_model,  0, 1'b0, 0, addr_count0, 16'd0);
        add_step(step_read_model,  0, 1'b0, 0, addr_count1, 16'd0);
        add_step(step_read_model,  0, 1'b0, 0, addr_status, 16'd0);
        add_step(step_read_model,  0, 1'b0, 0, addr_status, 16'd0);
        // Frozen shadow while channel 0 is disabled
        add_step(step_write,      0, 1'b0, 0, addr_ctrl,   16'd2);
        add_step(step_pulses,     0, 1'b0, 4, addr_ctrl,   16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_count0, 16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_status, 16'd0);
        add_step(step_write,      0, 1'b0, 0, addr_ctrl,   16'd3);
        add_step(step_pulses,     0, 1'b0, 1, addr_ctrl,   16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_count0, 16'd0);
        // Sticky flags, cleared on read
        add_step(step_read_model, 0, 1'b0, 0, addr_status, 16'd0);
        add_step(step_pulses,     1, 1'b0, 2, addr_ctrl,   16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_status, 16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_status, 16'd0);
        add_step(step_pulses,     0, 1'b1, 1, addr_ctrl,   16'd0);
        add_step(step_pulses,     1, 1'b1, 1, addr_ctrl,   16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_status, 16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_status, 16'd0);
        // Short glitches are filtered out
        add_step(step_glitch,     0, 1'b0, 0, addr_ctrl,   16'd0);
        add_step(step_glitch,     1, 1'b0, 0, addr_ctrl,   16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_count0, 16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_count1, 16'd0);
        add_step(step_read_model, 0, 1'b0, 0, addr_status, 16'd0);
        add_step(step_read,       0, 1'b0, 0, addr_ctrl,   16'd3);
    endtask

    task automatic apply_step(input step_t s);
        logic [count_width-1:0] data;
        logic [count_width-1:0] expected;
        logic                   rdir;
        int                     rn;
        case (s.kind)
            step_write: begin
                write_reg(s.addr, s.value);
                if (s.addr == addr_ctrl) begin
                    exp_ctrl = s.value[num_channels-1:0];
                end
            end
            step_pulses: send_pulses(s.chan, s.dir, s.n);
            step_rand_pulses: begin
                rn   = $urandom_range(6, 1);
                rdir = 1'($urandom_range(1, 0));
                send_pulses(s.chan, rdir, rn);
            end
            step_glitch: send_glitch(s.chan);
            default: begin
                // Model value is taken before the read clears status
                if (s.kind == step_read_model) begin
                    expected = model_value(s.addr);
                end else begin
                    expected = s.value;
                end
                read_reg(s.addr, data);
                check_value($sformatf("rdata[%s]", s.addr.name()), expected, data);
                if (s.addr == addr_status) begin
                    exp_status = '0;
                end
            end
        endcase
    endtask

    // ##################################################
    // Main sequence
    // ##################################################

    initial begin
        void'($urandom(44));
        reset    = 1'b1;
        pulse_in = '0;
        dir_in   = '0;
        req      = '0;
        for (int c = 0; c < num_channels; c++) begin
            run_count[c] = '0;
            shadow[c]    = '0;
        end
        exp_ctrl   = '0;
        exp_status = '0;
        build_table();

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        wait_cycles(2);

        foreach (steps[i]) begin
            apply_step(steps[i]);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
encoder_pkg.sv
input_sync.sv
pulse_counter.sv
encoder_regs.sv
encoder_if_top.sv
tb_encoder_if.sv

/* Bender.yml */
package:
  name: encoder_if

sources:
  - encoder_pkg.sv
  - input_sync.sv
  - pulse_counter.sv
  - encoder_regs.sv
  - encoder_if_top.sv
  - target: simulation
    files:
      - tb_encoder_if.sv
